// File: vlog.f
+incdir+include
source/intra_pkg.sv
source/pipe_stage.sv
source/mode_decision.sv
source/core_transform.sv
source/coef_quantizer.sv
source/intra_encoder_top.sv
test/tb_intra_encoder.sv

// File: test/intra_cases.txt
# name qp top0-3 left0-3, then pix0-15 in raster order (row * 4 + column),
# then mode (0 vert, 1 hori, 2 dc) and levels0-15 in raster order
flat_dc 28  100 100 100 100  100 100 100 100
    100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
    2  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
vert_rows 0  40 80 120 160  100 100 100 100
    44 84 124 164 40 80 120 160 38 78 118 158 42 82 122 162
    0  6 0 0 0 6 0 0 0 13 0 0 0 -2 0 0 0
hori_cols 12  100 100 100 100  40 80 120 160
    44 40 38 42 84 80 78 82 124 120 118 122 164 160 158 162
    1  1 1 3 0 0 0 0 0 0 0 0 0 0 0 0 0
dc_offset 28  60 140 60 140  140 60 140 60
    95 95 95 95 95 95 95 95 95 95 95 95 95 95 95 95
    2  -1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# all three SADs equal, qp 31 clamps to 29
tie_three_clamp 31  60 140 60 140  140 60 140 60
    140 60 140 60 60 140 60 140 140 60 140 60 60 140 60 140
    2  0 0 0 0 0 1 0 2 0 0 0 0 0 2 0 8
# vert and hori SADs equal
tie_hv 0  102 98 96 100  100 100 100 100
    104 100 98 102 104 100 98 102 104 100 98 102 104 100 98 102
    1  6 6 13 -2 0 0 0 0 0 0 0 0 0 0 0 0
# vert and dc SADs equal
tie_vd 12  100 100 100 100  116 116 116 116
    104 104 104 104 104 104 104 104 104 104 104 104 104 104 104 104
    2  -6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
vert_checker 28  100 100 100 100  200 200 200 200
    140 60 140 60 60 140 60 140 140 60 140 60 60 140 60 140
    0  0 0 0 0 0 1 0 3 0 0 0 0 0 3 0 9

// File: test/tb_intra_encoder.sv
`timescale 1ns/1ps
`include "intra_settings.svh"

module tb_intra_encoder;

    import intra_pkg::*;

    typedef coef_t [`INTRA_BLK_N-1:0] level_set_t;

    localparam string CASE_FILE = "test/intra_cases.txt";
    // qp, top[4], left[4], pix[16], mode, levels[16]
    localparam int    N_FIELDS  = 42;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    block_in_t  in_data;
    logic       out_ready;
    logic       in_ready;
    logic       out_valid;
    coef_beat_t out_data;

    // cases in file order
    string      case_name [$];
    block_in_t  case_blk  [$];
    pred_mode_t case_mode [$];
    level_set_t case_lvl  [$];

    // scoreboard, one entry per expected beat
    coef_beat_t exp_beat [$];
    string      exp_name [$];

    int         seed        = 13781;
    int         cycle_count = 0;
    int         cycle_limit = 0;
    int         beats_seen  = 0;
    logic       bp_on;
    logic       stall_prev  = 1'b0;
    coef_beat_t held_beat;

    intra_encoder_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_value(input string name, input string field,
                               input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        if (actual !== expected) begin
            $display("Error %s %s: expected %0d actual %0d", name, field, expected, actual);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // ========================================================================
    // case file
    // ========================================================================

    task automatic load_cases();
        int         fd;
        int         code;
        string      tok;
        string      rest;
        int         field [N_FIELDS];
        block_in_t  blk;
        level_set_t lvl;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the case file %s", CASE_FILE);
            $display("Regression failed");
            $fatal(1, "no stimulus");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                // rest of a comment line
                code = $fgets(rest, fd);
            end else begin
                for (int k = 0; k < N_FIELDS; k++) begin
                    code = $fscanf(fd, "%d", field[k]);
                    if (code != 1) begin
                        $display("case %s in the case file is incomplete", tok);
                        $display("Regression failed");
                        $fatal(1, "bad case file");
                    end
                end
                blk.qp = qp_t'(field[0]);
                for (int k = 0; k < 4; k++) begin
                    blk.top[k]  = pixel_t'(field[1 + k]);
                    blk.left[k] = pixel_t'(field[5 + k]);
                end
                for (int k = 0; k < `INTRA_BLK_N; k++) begin
                    blk.pix[k] = pixel_t'(field[9 + k]);
                    lvl[k]     = coef_t'(field[26 + k]);
                end
                case_name.push_back(tok);
                case_blk.push_back(blk);
                case_mode.push_back(pred_mode_t'(field[25]));
                case_lvl.push_back(lvl);
            end
        end
        $fclose(fd);
    endtask

    // 16 beats per accepted job, last only on index 15
    task automatic queue_expected(input int c, input string tag);
        coef_beat_t beat;
        for (int k = 0; k < `INTRA_BLK_N; k++) begin
            beat.mode  = case_mode[c];
            beat.index = 4'(k);
            beat.last  = (k == `INTRA_BLK_N - 1);
            beat.level = case_lvl[c][k];
            exp_beat.push_back(beat);
            exp_name.push_back(tag);
        end
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================

    initial begin
        int    n_cases;
        int    n_jobs;
        int    c;
        string tag;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        bp_on     = 1'b0;
        load_cases();
        n_cases = case_blk.size();
        if (n_cases == 0) begin
            $display("the case file holds no cases");
            $display("Regression failed");
            $fatal(1, "no stimulus");
        end
        // first pass with a free output, second under random back-pressure
        n_jobs      = 2 * n_cases;
        cycle_limit = 64 * n_jobs + 200;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("reset", "out_valid", 0, out_valid);
        check_value("reset", "in_ready", 1, in_ready);

        for (int j = 0; j < n_jobs; j++) begin
            c = j % n_cases;
            if (j == n_cases) begin
                bp_on <= 1'b1;
            end
            tag      = (j < n_cases) ? case_name[c] : {case_name[c], "_bp"};
            in_valid <= 1'b1;
            in_data  <= case_blk[c];
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
            queue_expected(c, tag);
        end
        in_valid <= 1'b0;

        wait (beats_seen == n_jobs * `INTRA_BLK_N);
        // nothing extra may follow the last job, and the pipeline drains
        repeat (20) @(posedge clk);
        check_value("drain", "out_valid", 0, out_valid);
        check_value("drain", "in_ready", 1, in_ready);
        $display("Regression passed");
        $finish;
    end

    always @(posedge clk) begin
        int rnd;
        rnd = $random(seed);
        if (bp_on) begin
            out_ready <= rnd[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    // ========================================================================
    // monitor and timeout
    // ========================================================================

    always @(posedge clk) begin
        coef_beat_t want;
        string      name;
        if (rst_n) begin
            if (stall_prev) begin
                name = (exp_name.size() > 0) ? exp_name[0] : "no job";
                check_value(name, "held valid", 1, out_valid);
                check_value(name, "held beat", {9'd0, held_beat}, {9'd0, out_data});
            end
            if (out_valid && out_ready) begin
                if (exp_beat.size() == 0) begin
                    $display("output beat arrived with no job pending");
                    $display("Regression failed");
                    $fatal(1, "unexpected beat");
                end else begin
                    want = exp_beat.pop_front();
                    name = exp_name.pop_front();
                    check_value(name, "mode", want.mode, out_data.mode);
                    check_value(name, "index", want.index, out_data.index);
                    check_value(name, "last", want.last, out_data.last);
                    check_value(name, "level", $signed(want.level), $signed(out_data.level));
                    beats_seen = beats_seen + 1;
                end
            end
            stall_prev = out_valid && !out_ready;
            held_beat  = out_data;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: output stream stalled");
            $display("Regression failed");
            $fatal(1, "cycle limit reached");
        end
    end

endmodule

// File: source/intra_encoder_top.sv
`timescale 1ns/1ps

module intra_encoder_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  intra_pkg::block_in_t  in_data,
    input  logic                  out_ready,
    output logic                  in_ready,
    output logic                  out_valid,
    output intra_pkg::coef_beat_t out_data
);

    import intra_pkg::*;

    // stage_in to stage_res, through mode_decision
    logic          blk_valid;
    logic          blk_ready;
    block_in_t     blk_data;
    residual_blk_t res_comb;

    // stage_res to stage_coef, through core_transform
    logic          res_valid;
    logic          res_ready;
    residual_blk_t res_data;
    coef_blk_t     coef_comb;

    // stage_coef to quantizer
    logic          coef_valid;
    logic          coef_ready;
    coef_blk_t     coef_data;

    pipe_stage #(.payload_t(block_in_t)) stage_in (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (in_valid),
        .s_data  (in_data),
        .m_ready (blk_ready),
        .s_ready (in_ready),
        .m_valid (blk_valid),
        .m_data  (blk_data)
    );

    mode_decision u_mode_decision (
        .blk     (blk_data),
        .res_blk (res_comb)
    );

    pipe_stage #(.payload_t(residual_blk_t)) stage_res (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (blk_valid),
        .s_data  (res_comb),
        .m_ready (res_ready),
        .s_ready (blk_ready),
        .m_valid (res_valid),
        .m_data  (res_data)
    );

    core_transform u_core_transform (
        .res_blk  (res_data),
        .coef_blk (coef_comb)
    );

    pipe_stage #(.payload_t(coef_blk_t)) stage_coef (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (res_valid),
        .s_data  (coef_comb),
        .m_ready (coef_ready),
        .s_ready (res_ready),
        .m_valid (coef_valid),
        .m_data  (coef_data)
    );

    coef_quantizer u_coef_quantizer (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_valid   (coef_valid),
        .s_data    (coef_data),
        .out_ready (out_ready),
        .s_ready   (coef_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: source/coef_quantizer.sv
`timescale 1ns/1ps
`include "intra_settings.svh"

module coef_quantizer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  s_valid,
    input  intra_pkg::coef_blk_t  s_data,
    input  logic                  out_ready,
    output logic                  s_ready,
    output logic                  out_valid,
    output intra_pkg::coef_beat_t out_data
);

    import intra_pkg::*;

    coef_blk_t                blk_q;
    logic [3:0]               idx_q;
    logic                     busy_q;
    logic                     accept;
    logic                     beat_done;
    logic                     last_beat;
    coef_t                    coef_cur;
    logic                     coef_neg;
    logic [`INTRA_COEF_W-1:0] coef_mag;
    logic [2:0]               qp_div;
    logic [2:0]               qp_rem;
    logic [4:0]               qbits;
    logic [19:0]              f_round;
    logic [13:0]              mf_a;
    logic [13:0]              mf_b;
    logic [13:0]              mf_c;
    logic [13:0]              mf;
    logic [31:0]              product;
    logic [31:0]              mag_level;

    // ========================================================================
    // handshake and beat counter
    // ========================================================================

    assign last_beat = (idx_q == 4'hf);
    assign beat_done = busy_q && out_ready;
    // next block may enter on the edge the last beat leaves
    assign s_ready   = !busy_q || (out_ready && last_beat);
    assign accept    = s_valid && s_ready;
    assign out_valid = busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (beat_done) begin
            idx_q <= idx_q + 4'd1;
            if (last_beat) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            blk_q <= s_data;
        end
    end

    // ========================================================================
    // per-QP tables
    // ========================================================================

    // qp already clamped upstream, so qp_div stays within 0..4
    assign qp_div = 3'(blk_q.qp / 6);
    assign qp_rem = 3'(blk_q.qp % 6);
    assign qbits  = 5'(`INTRA_QBITS_BASE) + {2'b00, qp_div};

    // rounding offset, 2^qbits / 3
    always_comb begin
        case (qp_div)
            3'd0:    f_round = 20'd10922;
            3'd1:    f_round = 20'd21845;
            3'd2:    f_round = 20'd43690;
            3'd3:    f_round = 20'd87381;
            default: f_round = 20'd174762;
        endcase
    end

    always_comb begin
        case (qp_rem)
            3'd0: begin
                mf_a = 14'd13107;
                mf_b = 14'd5243;
                mf_c = 14'd8066;
            end
            3'd1: begin
                mf_a = 14'd11916;
                mf_b = 14'd4660;
                mf_c = 14'd7490;
            end
            3'd2: begin
                mf_a = 14'd10082;
                mf_b = 14'd4194;
                mf_c = 14'd6554;
            end
            3'd3: begin
                mf_a = 14'd9362;
                mf_b = 14'd3647;
                mf_c = 14'd5825;
            end
            3'd4: begin
                mf_a = 14'd8192;
                mf_b = 14'd3355;
                mf_c = 14'd5243;
            end
            default: begin
                mf_a = 14'd7282;
                mf_b = 14'd2893;
                mf_c = 14'd4559;
            end
        endcase
    end

    // position class: even row and col, odd row and col, mixed
    always_comb begin
        case (idx_q)
            4'd0, 4'd2, 4'd8, 4'd10:  mf = mf_a;
            4'd5, 4'd7, 4'd13, 4'd15: mf = mf_b;
            default:                  mf = mf_c;
        endcase
    end

    // ========================================================================
    // shared multiplier and output beat
    // ========================================================================

    assign coef_cur  = blk_q.coef[idx_q];
    assign coef_neg  = coef_cur[`INTRA_COEF_W-1];
    assign coef_mag  = coef_neg ? -coef_cur : coef_cur;
    assign product   = coef_mag * mf;
    assign mag_level = (product + f_round) >> qbits;

    always_comb begin
        out_data.mode  = blk_q.mode;
        out_data.index = idx_q;
        out_data.last  = last_beat;
        if (coef_neg) begin
            out_data.level = -coef_t'(mag_level[`INTRA_COEF_W-1:0]);
        end else begin
            out_data.level = coef_t'(mag_level[`INTRA_COEF_W-1:0]);
        end
    end

endmodule

// File: source/core_transform.sv
`timescale 1ns/1ps
`include "intra_settings.svh"

module core_transform (
    input  intra_pkg::residual_blk_t res_blk,
    output intra_pkg::coef_blk_t     coef_blk
);

    import intra_pkg::*;

    typedef coef_t [3:0] quad_t;

    quad_t row_in  [4];
    quad_t row_out [4];
    quad_t col_in  [4];
    quad_t col_out [4];

    // one 1-D pass of Cf on four samples
    function automatic quad_t butterfly(input quad_t x);
        coef_t s0;
        coef_t s1;
        coef_t d0;
        coef_t d1;
        quad_t y;
        s0   = x[0] + x[3];
        s1   = x[1] + x[2];
        d0   = x[0] - x[3];
        d1   = x[1] - x[2];
        y[0] = s0 + s1;
        y[1] = (d0 <<< 1) + d1;
        y[2] = s0 - s1;
        y[3] = d0 - (d1 <<< 1);
        return y;
    endfunction

    // ========================================================================
    // row pass, X times Cf transposed
    // ========================================================================

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                row_in[r][c] = coef_t'(res_blk.res[r * 4 + c]);
            end
            row_out[r] = butterfly(row_in[r]);
        end
    end

    // ========================================================================
    // column pass, Cf times the row result
    // ========================================================================

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                col_in[c][r] = row_out[r][c];
            end
            col_out[c] = butterfly(col_in[c]);
        end
    end

    // back to raster order
    always_comb begin
        coef_blk.qp   = res_blk.qp;
        coef_blk.mode = res_blk.mode;
        for (int j = 0; j < 4; j++) begin
            for (int c = 0; c < 4; c++) begin
                coef_blk.coef[j * 4 + c] = col_out[c][j];
            end
        end
    end

endmodule

// File: source/mode_decision.sv
`timescale 1ns/1ps
`include "intra_settings.svh"

module mode_decision (
    input  intra_pkg::block_in_t     blk,
    output intra_pkg::residual_blk_t res_blk
);

    import intra_pkg::*;

    logic [`INTRA_PIX_W+2:0] nb_sum;
    pixel_t                  dc_pred;
    residual_t               res_vert [`INTRA_BLK_N];
    residual_t               res_hori [`INTRA_BLK_N];
    residual_t               res_dc   [`INTRA_BLK_N];
    logic [`INTRA_PIX_W+3:0] sad_vert;
    logic [`INTRA_PIX_W+3:0] sad_hori;
    logic [`INTRA_PIX_W+3:0] sad_dc;
    pred_mode_t              mode;

    function automatic logic [`INTRA_RES_W-1:0] abs_res(input residual_t r);
        return r[`INTRA_RES_W-1] ? -r : r;
    endfunction

    // ========================================================================
    // predictions and SADs
    // ========================================================================

    // dc over 4 top and 4 left neighbours
    always_comb begin
        nb_sum = '0;
        for (int k = 0; k < 4; k++) begin
            nb_sum = nb_sum + blk.top[k] + blk.left[k];
        end
        dc_pred = pixel_t'(nb_sum >> 3);
    end

    always_comb begin
        sad_vert = '0;
        sad_hori = '0;
        sad_dc   = '0;
        for (int i = 0; i < `INTRA_BLK_N; i++) begin
            // vertical copies top[col], horizontal copies left[row]
            res_vert[i] = residual_t'({1'b0, blk.pix[i]} - {1'b0, blk.top[i % 4]});
            res_hori[i] = residual_t'({1'b0, blk.pix[i]} - {1'b0, blk.left[i / 4]});
            res_dc[i]   = residual_t'({1'b0, blk.pix[i]} - {1'b0, dc_pred});
            sad_vert = sad_vert + abs_res(res_vert[i]);
            sad_hori = sad_hori + abs_res(res_hori[i]);
            sad_dc   = sad_dc + abs_res(res_dc[i]);
        end
    end

    // ========================================================================
    // mode choice
    // ========================================================================

    // ties fall towards horizontal first, then dc over vertical
    always_comb begin
        if (sad_vert >= sad_hori && sad_dc > sad_hori) begin
            mode = PRED_HORI;
        end else if (sad_hori > sad_vert && sad_dc > sad_vert) begin
            mode = PRED_VERT;
        end else begin
            mode = PRED_DC;
        end
    end

    always_comb begin
        if (blk.qp > qp_t'(`INTRA_QP_MAX)) begin
            res_blk.qp = qp_t'(`INTRA_QP_MAX);
        end else begin
            res_blk.qp = blk.qp;
        end
        res_blk.mode = mode;
        for (int i = 0; i < `INTRA_BLK_N; i++) begin
            case (mode)
                PRED_VERT: res_blk.res[i] = res_vert[i];
                PRED_HORI: res_blk.res[i] = res_hori[i];
                default:   res_blk.res[i] = res_dc[i];
            endcase
        end
    end

endmodule

// File: source/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     s_valid,
    input  payload_t s_data,
    input  logic     m_ready,
    output logic     s_ready,
    output logic     m_valid,
    output payload_t m_data
);

    logic     valid_q;
    payload_t data_q;
    logic     accept;

    // empty, or the held item leaves this cycle
    assign s_ready = !valid_q || m_ready;
    assign accept  = s_valid && s_ready;

    assign m_valid = valid_q;
    assign m_data  = data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (m_ready) begin
            valid_q <= 1'b0;
        end
    end

    // payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= s_data;
        end
    end

endmodule

// File: source/intra_pkg.sv
`include "intra_settings.svh"

package intra_pkg;

    // ========================================================================
    // scalar types
    // ========================================================================

    typedef logic        [`INTRA_PIX_W-1:0]  pixel_t;
    typedef logic signed [`INTRA_RES_W-1:0]  residual_t;
    typedef logic signed [`INTRA_COEF_W-1:0] coef_t;
    typedef logic        [`INTRA_QP_W-1:0]   qp_t;

    typedef enum logic [1:0] {
        PRED_VERT = 2'd0,
        PRED_HORI = 2'd1,
        PRED_DC   = 2'd2
    } pred_mode_t;

    // ========================================================================
    // pipeline payloads
    // ========================================================================

    // one job, samples in raster order (row * 4 + column)
    typedef struct packed {
        qp_t                          qp;
        pixel_t [3:0]                 top;
        pixel_t [3:0]                 left;
        pixel_t [`INTRA_BLK_N-1:0]    pix;
    } block_in_t;

    typedef struct packed {
        qp_t                          qp;
        pred_mode_t                   mode;
        residual_t [`INTRA_BLK_N-1:0] res;
    } residual_blk_t;

    typedef struct packed {
        qp_t                          qp;
        pred_mode_t                   mode;
        coef_t [`INTRA_BLK_N-1:0]     coef;
    } coef_blk_t;

    // one quantized level per output beat
    typedef struct packed {
        pred_mode_t                   mode;
        logic [3:0]                   index;
        logic                         last;
        coef_t                        level;
    } coef_beat_t;

endpackage

// File: include/intra_settings.svh
`ifndef INTRA_SETTINGS_SVH
`define INTRA_SETTINGS_SVH

// sample geometry
`define INTRA_PIX_W      8
`define INTRA_BLK_N      16

// signed datapath widths
`define INTRA_RES_W      9
`define INTRA_COEF_W     16

// quantizer parameter range
`define INTRA_QP_W       5
`define INTRA_QP_MAX     29

// qbits for the first QP period, one more per period of 6
`define INTRA_QBITS_BASE 15

`endif
